// ==== design/lc3b_isa_pkg.sv ====
package lc3b_isa_pkg;

	// datapath word and register index widths
	localparam int word_w    = 16;
	localparam int reg_idx_w = 3;

	// one iteration per operand bit for both mult and div
	localparam int muldiv_steps = word_w;
	localparam int muldiv_cnt_w = $clog2(muldiv_steps);

	// execute-stage operation select
	// the first seven are handled in one cycle by the alu,
	// mult and div go to the iterative unit and stall the pipe
	typedef enum logic [3:0]
	{
		alu_add  = 4'd0,
		alu_and  = 4'd1,
		alu_not  = 4'd2,
		alu_pass = 4'd3,
		alu_sll  = 4'd4,
		alu_srl  = 4'd5,
		alu_sra  = 4'd6,
		alu_mult = 4'd7, // low half of unsigned product
		alu_div  = 4'd8  // unsigned quotient
	} lc3b_aluop;

endpackage : lc3b_isa_pkg

// ==== design/lc3b_pipe_pkg.sv ====
package lc3b_pipe_pkg;

	import lc3b_isa_pkg::*;

	// decoded request held in the id/ex register
	typedef struct packed
	{
		logic                 valid; // low for a bubble
		lc3b_aluop            aluop;
		logic [word_w-1:0]    sr1;   // first source operand
		logic [word_w-1:0]    sr2;   // second source operand or shift amount
		logic [reg_idx_w-1:0] dest;  // destination register index
	} ex_req_t;

	// result held in the ex/mem register
	typedef struct packed
	{
		logic                 valid; // low while the stage is stalled
		logic [word_w-1:0]    value;
		logic [reg_idx_w-1:0] dest;
	} ex_res_t;

endpackage : lc3b_pipe_pkg

// ==== design/lc3b_alu.sv ====
module lc3b_alu
(
	input  lc3b_isa_pkg::lc3b_aluop             aluop,
	input  logic [lc3b_isa_pkg::word_w-1:0]     a,
	input  logic [lc3b_isa_pkg::word_w-1:0]     b,
	output logic [lc3b_isa_pkg::word_w-1:0]     f
);

	import lc3b_isa_pkg::*;

	logic [muldiv_cnt_w-1:0] shamt; // shift amount from low bits of b

	assign shamt = b[muldiv_cnt_w-1:0];

	always_comb
	begin
		case (aluop)
			alu_add:
				f = a + b;
			alu_and:
				f = a & b;
			alu_not:
				f = ~a;
			alu_pass:
				f = a; // pass sr1 through unchanged
			alu_sll:
				f = a << shamt;
			alu_srl:
				f = a >> shamt;
			alu_sra:
				f = $signed(a) >>> shamt; // sign bit fills from the left
			default:
				f = '0; // mult and div are not computed here
		endcase
	end

endmodule : lc3b_alu

// ==== design/lc3b_muldiv.sv ====
module lc3b_muldiv
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                go,
	input  lc3b_isa_pkg::lc3b_aluop             op,
	input  logic [lc3b_isa_pkg::word_w-1:0]     a,
	input  logic [lc3b_isa_pkg::word_w-1:0]     b,
	output logic [lc3b_isa_pkg::word_w-1:0]     result,
	output logic                                done
);

	import lc3b_isa_pkg::*;

	// idle -> run for a fixed number of steps -> finish for one cycle
	typedef enum logic [1:0]
	{
		st_idle,
		st_run,
		st_finish
	} state_t;

	state_t                  state;
	state_t                  state_nxt;
	logic [muldiv_cnt_w-1:0] cnt;       // step counter within run
	logic                    last_step;
	logic                    load;      // operands captured this cycle

	logic [word_w-1:0]       acc;       // high half of product, or remainder
	logic [word_w-1:0]       opr;       // multiplier or dividend, ends as result
	logic [word_w-1:0]       den;       // multiplicand or divisor
	logic                    is_div;
	logic                    div_zero;  // divisor was zero at load

	logic [word_w:0]         mul_sum;   // acc plus selected multiplicand
	logic [word_w:0]         div_shl;   // remainder shifted with next dividend bit
	logic [word_w-1:0]       div_diff;
	logic                    div_fits;  // trial subtract does not borrow

	assign load      = (state == st_idle) && go;
	assign last_step = (cnt == muldiv_cnt_w'(muldiv_steps - 1));

	always_comb
	begin
		state_nxt = state;
		case (state)
			st_idle:
			begin
				if (go)
					state_nxt = st_run;
			end
			st_run:
			begin
				if (last_step)
					state_nxt = st_finish;
			end
			st_finish:
				state_nxt = st_idle; // always back to idle so the next op restarts
			default:
				state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_idle;
			cnt   <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (state == st_run)
				cnt <= cnt + 1'b1; // wraps to zero after the last step
			else
				cnt <= '0;
		end
	end

	// shift-add multiply, product shifts right through acc and opr
	assign mul_sum = {1'b0, acc} + (opr[0] ? {1'b0, den} : {(word_w + 1){1'b0}});

	// restoring divide, one quotient bit per step
	assign div_shl  = {acc, opr[word_w-1]};
	assign div_fits = (div_shl >= {1'b0, den});
	assign div_diff = div_shl[word_w-1:0] - den; // only kept when it fits

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			acc      <= '0;
			opr      <= a;
			den      <= b;
			is_div   <= (op == alu_div);
			div_zero <= (op == alu_div) && (b == '0);
		end
		else if (state == st_run)
		begin
			if (is_div)
			begin
				if (div_fits)
				begin
					acc <= div_diff;
					opr <= {opr[word_w-2:0], 1'b1};
				end
				else
				begin
					acc <= div_shl[word_w-1:0]; // restore
					opr <= {opr[word_w-2:0], 1'b0};
				end
			end
			else
			begin
				acc <= mul_sum[word_w:1];
				opr <= {mul_sum[0], opr[word_w-1:1]};
			end
		end
	end

	// divide by zero still runs all steps, only the reported value changes
	assign result = div_zero ? '1 : opr;
	assign done   = (state == st_finish);

endmodule : lc3b_muldiv

// ==== design/lc3b_stage_reg.sv ====
module lc3b_stage_reg
#(
	parameter type payload_t = lc3b_pipe_pkg::ex_req_t
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     hold,   // keep the current item
	input  logic     bubble, // load an empty item
	input  payload_t d,
	output payload_t q
);

	// all-zero payload carries valid low in either struct
	always_ff @(posedge clk)
	begin
		if (rst || bubble)
			q <= '0;
		else if (!hold)
			q <= d;
	end

endmodule : lc3b_stage_reg

// ==== design/lc3b_ex_unit.sv ====
module lc3b_ex_unit
(
	input  logic                       clk,
	input  logic                       rst,
	input  lc3b_pipe_pkg::ex_req_t     cur,
	output lc3b_pipe_pkg::ex_res_t     nxt,
	output logic                       stall
);

	import lc3b_isa_pkg::*;

	logic              go;        // valid mult or div sits in id/ex
	logic              done;
	logic [word_w-1:0] alu_f;
	logic [word_w-1:0] md_result;

	// only place where the op class is decided
	assign go = cur.valid && ((cur.aluop == alu_mult) || (cur.aluop == alu_div));

	lc3b_alu alu
	(
		.aluop (cur.aluop),
		.a     (cur.sr1),
		.b     (cur.sr2),
		.f     (alu_f)
	);

	lc3b_muldiv muldiv
	(
		.clk    (clk),
		.rst    (rst),
		.go     (go),
		.op     (cur.aluop),
		.a      (cur.sr1),
		.b      (cur.sr2),
		.result (md_result),
		.done   (done)
	);

	// hold the pipe until the iterative unit reports done
	assign stall = go && !done;

	assign nxt.valid = cur.valid;
	assign nxt.value = done ? md_result : alu_f;
	assign nxt.dest  = cur.dest;

endmodule : lc3b_ex_unit

// ==== design/lc3b_execute.sv ====
module lc3b_execute
(
	input  logic                       clk,
	input  logic                       rst,
	input  lc3b_pipe_pkg::ex_req_t     req,
	output lc3b_pipe_pkg::ex_res_t     res,
	output logic                       stall
);

	import lc3b_pipe_pkg::*;

	ex_req_t cur; // id/ex register contents
	ex_res_t nxt; // value heading into ex/mem

	// id/ex holds while the execute unit is busy
	lc3b_stage_reg #(.payload_t(ex_req_t)) id_ex
	(
		.clk    (clk),
		.rst    (rst),
		.hold   (stall),
		.bubble (1'b0),
		.d      (req),
		.q      (cur)
	);

	lc3b_ex_unit ex_unit
	(
		.clk   (clk),
		.rst   (rst),
		.cur   (cur),
		.nxt   (nxt),
		.stall (stall)
	);

	// ex/mem takes bubbles during a stall instead of holding
	lc3b_stage_reg #(.payload_t(ex_res_t)) ex_mem
	(
		.clk    (clk),
		.rst    (rst),
		.hold   (1'b0),
		.bubble (stall),
		.d      (nxt),
		.q      (res)
	);

endmodule : lc3b_execute

// ==== verification/execute_props.sv ====
module execute_props
(
	input logic                   clk,
	input logic                   rst,
	input lc3b_pipe_pkg::ex_req_t cur,
	input lc3b_pipe_pkg::ex_res_t res,
	input logic                   stall
);

	timeunit 1ns;
	timeprecision 100ps;

	import lc3b_isa_pkg::*;
	import lc3b_pipe_pkg::*;

	int unsigned stall_len;      // stalled cycles in the current run
	logic        multi_op;       // id/ex holds a valid mult or div
	int unsigned fail_count = 0; // failed assertions so far

	assign multi_op = cur.valid && (cur.aluop == alu_mult || cur.aluop == alu_div);

	always_ff @(posedge clk)
	begin
		if (rst)
			stall_len <= 0;
		else if (stall)
			stall_len <= stall_len + 1;
		else
			stall_len <= 0;
	end

	reset_clear: assert property (@(posedge clk) rst |=> !stall && !res.valid)
		else
		begin
			fail_count++;
			$error("stall or res.valid high after a reset edge");
		end

	// a freshly accepted mult or div finds the unit idle and stalls at once
	stall_start: assert property (@(posedge clk) disable iff (rst)
		multi_op && !$past(stall) |-> stall)
		else
		begin
			fail_count++;
			$error("mult or div in id/ex did not raise stall");
		end

	stall_max: assert property (@(posedge clk) disable iff (rst) stall |-> stall_len < 17)
		else
		begin
			fail_count++;
			$error("stall high for more than 17 cycles");
		end

	stall_exact: assert property (@(posedge clk) disable iff (rst)
		$fell(stall) |-> stall_len == 17)
		else
		begin
			fail_count++;
			$error("stall run was not exactly 17 cycles");
		end

	hold_on_stall: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(cur))
		else
		begin
			fail_count++;
			$error("id/ex changed while stalled");
		end

	bubble_on_stall: assert property (@(posedge clk) disable iff (rst) stall |=> !res.valid)
		else
		begin
			fail_count++;
			$error("valid result captured during a stall");
		end

	// every item leaving execute lands in ex/mem on the next edge
	result_follows: assert property (@(posedge clk) disable iff (rst)
		cur.valid && !stall |=> res.valid && res.dest == $past(cur.dest))
		else
		begin
			fail_count++;
			$error("result missing or with wrong dest after execute");
		end

	no_phantom: assert property (@(posedge clk) disable iff (rst) !cur.valid |=> !res.valid)
		else
		begin
			fail_count++;
			$error("valid result from an empty id/ex");
		end

endmodule : execute_props

bind lc3b_execute execute_props props
(
	.clk   (clk),
	.rst   (rst),
	.cur   (cur),
	.res   (res),
	.stall (stall)
);

// ==== verification/tb_execute.sv ====
module tb_execute;

	timeunit 1ns;
	timeprecision 100ps;

	import lc3b_isa_pkg::*;
	import lc3b_pipe_pkg::*;

	// one outstanding result and the edge count at which it must be sampled
	typedef struct packed
	{
		logic [word_w-1:0]    value;
		logic [reg_idx_w-1:0] dest;
		logic [31:0]          due;
	} exp_t;

	logic    clk;
	logic    rst;
	ex_req_t req;
	ex_res_t res;
	logic    stall;

	exp_t                 expected[$];     // results in issue order
	int unsigned          edges = 0;       // rising edges seen so far
	int unsigned          wait_limit = 2 * muldiv_steps + 8;
	int                   seed;
	string                test_name;
	logic [reg_idx_w-1:0] dest_cnt;
	int unsigned          test_checks = 0;
	int unsigned          test_errors = 0;
	int unsigned          total_checks = 0;
	int unsigned          total_errors = 0;

	lc3b_execute UUT
	(
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.res   (res),
		.stall (stall)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	function automatic void count_check();
		test_checks++;
		total_checks++;
	endfunction

	function automatic void count_error();
		test_errors++;
		total_errors++;
	endfunction

	function automatic logic [word_w-1:0] rnd16();
		int r;
		r = $random(seed);
		return r[word_w-1:0];
	endfunction

	// expected value straight from the instruction definitions
	function automatic logic [word_w-1:0] model(input lc3b_aluop op, input logic [word_w-1:0] a,
		input logic [word_w-1:0] b);
		logic [2*word_w-1:0] prod;
		logic [word_w-1:0]   r;
		int                  sh;
		int                  i;
		prod = {{word_w{1'b0}}, a} * {{word_w{1'b0}}, b};
		sh = int'(b[3:0]);
		r = a;
		case (op)
			alu_add:  r = a + b;
			alu_and:  r = a & b;
			alu_not:  r = ~a;
			alu_pass: r = a;
			alu_sll:  r = a << sh;
			alu_srl:  r = a >> sh;
			alu_sra:
			begin
				for (i = 0; i < sh; i++)
					r = {r[word_w-1], r[word_w-1:1]}; // sign bit copied in from the top
			end
			alu_mult: r = prod[word_w-1:0];
			alu_div:  r = (b == '0) ? '1 : a / b;
			default:  r = '0;
		endcase
		return r;
	endfunction

	// junk that a stalled id/ex must not pick up
	task automatic scramble_req();
		req.valid = 1'b1;
		req.aluop = alu_add;
		req.sr1   = rnd16();
		req.sr2   = rnd16();
		req.dest  = 3'd7;
	endtask

	task automatic wait_stall_low();
		int unsigned waited;
		waited = 0;
		@(negedge clk);
		while (stall && waited < wait_limit)
		begin
			scramble_req();
			waited++;
			@(negedge clk);
		end
		if (stall)
		begin
			$display("%s: stall still high after %0d cycles", test_name, wait_limit);
			count_error();
		end
	endtask

	// present one request, accepted at the next rising edge
	task automatic issue(input lc3b_aluop op, input logic [word_w-1:0] a,
		input logic [word_w-1:0] b);
		exp_t e;
		wait_stall_low();
		dest_cnt  = dest_cnt + 3'd1;
		req.valid = 1'b1;
		req.aluop = op;
		req.sr1   = a;
		req.sr2   = b;
		req.dest  = dest_cnt;
		e.value = model(op, a, b);
		e.dest  = dest_cnt;
		if (op == alu_mult || op == alu_div)
			e.due = edges + 19; // 18 edges after acceptance
		else
			e.due = edges + 2;
		expected.push_back(e);
	endtask

	task automatic drain();
		int unsigned waited;
		wait_stall_low();
		req = '0;
		waited = 0;
		while (expected.size() != 0 && waited < wait_limit)
		begin
			waited++;
			@(negedge clk);
		end
		if (expected.size() != 0)
		begin
			$display("%s: %0d results never arrived", test_name, expected.size());
			count_error();
			expected.delete();
		end
	endtask

	task automatic check_idle();
		count_check();
		assert (stall === 1'b0 && res.valid === 1'b0)
		else
		begin
			$display("[ERROR] %s: expected stall 0 res.valid 0, actual stall %b res.valid %b",
				test_name, stall, res.valid);
			count_error();
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		drain();
		$display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
	endtask

	// res changed after the previous edge, so it is stable here
	always @(posedge clk)
	begin
		exp_t head;
		if (!rst && res.valid === 1'b1)
		begin
			if (expected.size() == 0)
			begin
				$display("%s: result %h for r%0d arrived with nothing outstanding",
					test_name, res.value, res.dest);
				count_error();
			end
			else
			begin
				head = expected.pop_front();
				count_check();
				assert (res.value == head.value && res.dest == head.dest)
				else
				begin
					$display("[ERROR] %s: expected %h r%0d, actual %h r%0d", test_name,
						head.value, head.dest, res.value, res.dest);
					count_error();
				end
				assert (edges == head.due)
				else
				begin
					$display("[ERROR] %s: expected arrival edge %0d, actual edge %0d",
						test_name, head.due, edges);
					count_error();
				end
			end
		end
		edges++;
	end

	initial
	begin
		seed     = 32'h3737_7355;
		rst      = 1'b1;
		req      = '0;
		dest_cnt = '0;

		start_test("reset");
		repeat (4)
		begin
			@(negedge clk);
			check_idle();
		end
		rst = 1'b0;
		@(negedge clk);
		check_idle();
		end_test();

		start_test("single");
		for (int round = 0; round < 4; round++)
		begin
			for (int i = 0; i < 7; i++)
				issue(lc3b_aluop'(i[3:0]), rnd16(), rnd16());
		end
		end_test();

		start_test("mult");
		issue(alu_mult, 16'h0000, rnd16());
		issue(alu_mult, rnd16(), 16'h0000);
		issue(alu_mult, 16'h0001, rnd16());
		issue(alu_mult, rnd16(), 16'h0001);
		issue(alu_mult, 16'hffff, 16'hffff);
		repeat (4)
			issue(alu_mult, rnd16(), rnd16());
		end_test();

		start_test("div");
		issue(alu_div, rnd16(), 16'h0001);
		issue(alu_div, 16'h0005, 16'h0009); // dividend below divisor
		issue(alu_div, rnd16(), 16'h0000);
		issue(alu_div, 16'h0000, 16'h0007);
		issue(alu_div, 16'hffff, 16'hffff);
		repeat (4)
			issue(alu_div, rnd16(), rnd16() >> 8);
		end_test();

		start_test("mixed");
		issue(alu_mult, rnd16(), rnd16());
		issue(alu_div, rnd16(), rnd16() >> 4);
		issue(alu_add, rnd16(), rnd16());
		issue(alu_sra, rnd16(), rnd16());
		issue(alu_not, rnd16(), rnd16());
		issue(alu_div, rnd16(), 16'h0000);
		issue(alu_pass, rnd16(), rnd16());
		end_test();

		total_errors += UUT.props.fail_count; // concurrent timing assertions
		$display("total: %0d checks, %0d errors", total_checks, total_errors);
		if (total_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule : tb_execute

// ==== src.f ====
design/lc3b_isa_pkg.sv
design/lc3b_pipe_pkg.sv
design/lc3b_alu.sv
design/lc3b_muldiv.sv
design/lc3b_stage_reg.sv
design/lc3b_ex_unit.sv
design/lc3b_execute.sv
verification/execute_props.sv
verification/tb_execute.sv

// ==== Makefile ====
SIM_TOOL  = verilator
SIM_FLAGS = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_execute
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TESTS FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with $(SIM_TOOL), run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

# an aborted simulation also counts as a failure
test:
	$(SIM_TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
